// ==== common/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// memory depths in words, keep to powers of two
`define MIPS_IMEM_WORDS 256
`define MIPS_DMEM_WORDS 256

// fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== common/mips_pkg.sv ====
package mips_pkg;

  // datapath widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [15:0] imm_t;

  // alu operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_t;

  // major opcodes
  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_J     = 6'h02;
  localparam opcode_t OP_JAL   = 6'h03;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;

  // r-type function codes
  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;

  // jal link register
  localparam reg_addr_t REG_RA = 5'd31;

endpackage

// ==== common/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if;
  import mips_pkg::*;

  // write-back and memory controls
  logic      reg_write;
  reg_addr_t waddr;
  logic      mem_write;
  logic      mem_to_reg;
  logic      link;
  // execute controls
  logic      alu_src_imm;
  alu_op_t   alu_op;
  word_t     imm_ext;
  // flow controls
  logic        branch_eq;
  logic        branch_ne;
  logic        jump;
  logic [25:0] jump_index;

  modport decoder (
    output reg_write, waddr, mem_write, mem_to_reg, link,
    output alu_src_imm, alu_op, imm_ext,
    output branch_eq, branch_ne, jump, jump_index
  );

  // next-address selection
  modport pc (input branch_eq, branch_ne, jump, jump_index, imm_ext);

  // operand and write-back select
  modport exec (input alu_src_imm, alu_op, mem_to_reg, link, imm_ext);

endinterface

// ==== src/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder (
  input  logic           reset,
  input  mips_pkg::word_t instr,
  ctrl_if.decoder         ctl
);
  import mips_pkg::*;

  // instruction fields
  opcode_t   opcode;
  reg_addr_t rt;
  reg_addr_t rd;
  imm_t      imm;
  funct_t    funct;

  assign opcode = instr[31:26];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = instr[15:0];
  assign funct  = instr[5:0];

  always_comb begin
    // defaults give a no-op
    ctl.reg_write   = 1'b0;
    ctl.mem_write   = 1'b0;
    ctl.mem_to_reg  = 1'b0;
    ctl.link        = 1'b0;
    ctl.alu_src_imm = 1'b0;
    ctl.alu_op      = ALU_ADD;
    ctl.branch_eq   = 1'b0;
    ctl.branch_ne   = 1'b0;
    ctl.jump        = 1'b0;
    ctl.waddr       = rt;
    ctl.imm_ext     = {{16{imm[15]}}, imm};
    ctl.jump_index  = instr[25:0];

    case (opcode)
      OP_RTYPE: begin
        ctl.waddr = rd;
        // unknown funct stays a no-op
        case (funct)
          FN_ADD: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_ADD;
          end
          FN_SUB: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_SUB;
          end
          FN_AND: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_AND;
          end
          FN_OR: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_OR;
          end
          FN_SLT: begin
            ctl.reg_write = 1'b1;
            ctl.alu_op    = ALU_SLT;
          end
          default: ;
        endcase
      end
      OP_ADDI: begin
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
      end
      OP_LW: begin
        // base plus offset, result from memory
        ctl.reg_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
        ctl.mem_to_reg  = 1'b1;
      end
      OP_SW: begin
        ctl.mem_write   = 1'b1;
        ctl.alu_src_imm = 1'b1;
      end
      OP_BEQ: begin
        // compare by subtraction, zero flag decides
        ctl.branch_eq = 1'b1;
        ctl.alu_op    = ALU_SUB;
      end
      OP_BNE: begin
        ctl.branch_ne = 1'b1;
        ctl.alu_op    = ALU_SUB;
      end
      OP_J: begin
        ctl.jump = 1'b1;
      end
      OP_JAL: begin
        ctl.jump      = 1'b1;
        ctl.link      = 1'b1;
        ctl.reg_write = 1'b1;
        ctl.waddr     = REG_RA;
      end
      default: ;
    endcase

    // no commits while reset is high
    if (reset) begin
      ctl.reg_write = 1'b0;
      ctl.mem_write = 1'b0;
    end
  end

endmodule

// ==== src/pc_unit.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module pc_unit (
  input  logic            clk,
  input  logic            reset,
  ctrl_if.pc              ctl,
  input  logic            zero,
  output mips_pkg::word_t pc,
  output mips_pkg::word_t pc_plus4
);
  import mips_pkg::*;

  word_t branch_target;
  word_t jump_target;
  word_t pc_next;
  logic  branch_taken;

  assign pc_plus4 = pc + 32'd4;

  // word offset relative to the following instruction
  assign branch_target = pc_plus4 + {ctl.imm_ext[29:0], 2'b00};

  // pseudo-direct, keeps the current 256 MB region
  assign jump_target = {pc_plus4[31:28], ctl.jump_index, 2'b00};

  // beq on equal, bne on not equal
  assign branch_taken = (ctl.branch_eq & zero) | (ctl.branch_ne & ~zero);

  always_comb begin
    pc_next = pc_plus4;
    if (ctl.jump) begin
      pc_next = jump_target;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end
  end

  // one step per clock
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `MIPS_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== src/regfile.sv ====
`timescale 1ns/1ps

module regfile (
  input  logic                clk,
  input  mips_pkg::reg_addr_t raddr1,
  input  mips_pkg::reg_addr_t raddr2,
  input  mips_pkg::reg_addr_t waddr,
  input  logic                we,
  input  mips_pkg::word_t     wdata,
  output mips_pkg::word_t     rdata1,
  output mips_pkg::word_t     rdata2
);
  import mips_pkg::*;

  // register 0 has no storage
  word_t regs [1:31];

  // asynchronous reads, zero register hardwired
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // writes to register 0 are dropped
  always_ff @(posedge clk) begin
    if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  ctrl_if.exec            ctl,
  input  mips_pkg::word_t rdata1,
  input  mips_pkg::word_t rdata2,
  input  mips_pkg::word_t pc_plus4,
  input  mips_pkg::word_t mem_rdata,
  output mips_pkg::word_t alu_result,
  output mips_pkg::word_t wb_data,
  output logic            zero
);
  import mips_pkg::*;

  word_t op_b;

  // immediate for addi and memory ops
  assign op_b = ctl.alu_src_imm ? ctl.imm_ext : rdata2;

  always_comb begin
    case (ctl.alu_op)
      ALU_ADD: alu_result = rdata1 + op_b;
      ALU_SUB: alu_result = rdata1 - op_b;
      ALU_AND: alu_result = rdata1 & op_b;
      ALU_OR:  alu_result = rdata1 | op_b;
      // signed compare, result is 0 or 1
      ALU_SLT: alu_result = ($signed(rdata1) < $signed(op_b)) ? 32'd1 : 32'd0;
      default: alu_result = '0;
    endcase
  end

  // branch condition source
  assign zero = (alu_result == '0);

  // link wins, then load data, then alu
  always_comb begin
    if (ctl.link) begin
      wb_data = pc_plus4;
    end else if (ctl.mem_to_reg) begin
      wb_data = mem_rdata;
    end else begin
      wb_data = alu_result;
    end
  end

endmodule

// ==== src/instr_mem.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module instr_mem #(
  parameter int DEPTH = `MIPS_IMEM_WORDS
) (
  input  logic            clk,
  input  logic            load_we,
  input  mips_pkg::word_t load_addr,
  input  mips_pkg::word_t load_data,
  input  mips_pkg::word_t addr,
  output mips_pkg::word_t instr
);
  import mips_pkg::*;

  // word index width, wraps modulo DEPTH
  localparam int AW = $clog2(DEPTH);

  word_t mem [DEPTH];

  // program load, top level only enables this in reset
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr[AW+1:2]] <= load_data;
    end
  end

  // fetch
  assign instr = mem[addr[AW+1:2]];

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module data_ram #(
  parameter int DEPTH = `MIPS_DMEM_WORDS
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            we,
  input  mips_pkg::word_t addr,
  input  mips_pkg::word_t wdata,
  output mips_pkg::word_t rdata
);
  import mips_pkg::*;

  localparam int AW = $clog2(DEPTH);

  word_t mem [DEPTH];

  // clear every word in reset, otherwise store
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[addr[AW+1:2]] <= wdata;
    end
  end

  // load data available in the same cycle
  assign rdata = mem[addr[AW+1:2]];

endmodule

// ==== src/mips_cpu.sv ====
`timescale 1ns/1ps

module mips_cpu (
  input  logic                clk,
  input  logic                reset,
  input  logic                load_we,
  input  mips_pkg::word_t     load_addr,
  input  mips_pkg::word_t     load_data,
  output mips_pkg::word_t     pc,
  output mips_pkg::word_t     rf_wdata,
  output mips_pkg::word_t     dm_addr,
  output mips_pkg::word_t     dm_wdata,
  output mips_pkg::reg_addr_t rf_waddr,
  output logic                rf_we,
  output logic                dm_we
);
  import mips_pkg::*;

  word_t     instr;
  word_t     pc_plus4;
  word_t     rdata1;
  word_t     rdata2;
  word_t     alu_result;
  word_t     wb_data;
  word_t     mem_rdata;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  logic      zero;
  logic      imem_load;

  // decoded control bus
  ctrl_if ctl ();

  // program load only while held in reset
  assign imem_load = load_we & reset;

  // rs and rt source fields
  assign raddr1 = instr[25:21];
  assign raddr2 = instr[20:16];

  pc_unit pc_unit_i (
    .clk      (clk),
    .reset    (reset),
    .ctl      (ctl.pc),
    .zero     (zero),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  instr_mem instr_mem_i (
    .clk       (clk),
    .load_we   (imem_load),
    .load_addr (load_addr),
    .load_data (load_data),
    .addr      (pc),
    .instr     (instr)
  );

  control_decoder control_decoder_i (
    .reset (reset),
    .instr (instr),
    .ctl   (ctl.decoder)
  );

  regfile regfile_i (
    .clk    (clk),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .waddr  (ctl.waddr),
    .we     (ctl.reg_write),
    .wdata  (wb_data),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  execute_unit execute_unit_i (
    .ctl        (ctl.exec),
    .rdata1     (rdata1),
    .rdata2     (rdata2),
    .pc_plus4   (pc_plus4),
    .mem_rdata  (mem_rdata),
    .alu_result (alu_result),
    .wb_data    (wb_data),
    .zero       (zero)
  );

  // alu result is the effective address, rt is store data
  data_ram data_ram_i (
    .clk   (clk),
    .reset (reset),
    .we    (ctl.mem_write),
    .addr  (alu_result),
    .wdata (rdata2),
    .rdata (mem_rdata)
  );

  // retire trace, values that commit at the next edge
  assign rf_we    = ctl.reg_write;
  assign rf_waddr = ctl.waddr;
  assign rf_wdata = wb_data;
  assign dm_we    = ctl.mem_write;
  assign dm_addr  = alu_result;
  assign dm_wdata = rdata2;

endmodule

// ==== testbench/mips_cpu_chk.sv ====
`timescale 1ns/1ps

module mips_cpu_chk (
  input logic            clk,
  input logic            reset,
  input mips_pkg::word_t pc,
  input logic            rf_we,
  input logic            dm_we
);

  // number of failed properties
  int unsigned fail_count = 0;

  // no commits while reset is high
  a_no_write_in_reset: assert property (
    @(posedge clk) reset |-> (!rf_we && !dm_we)
  ) else begin
    fail_count++;
    $error("write enable high while reset is asserted");
  end

  // fetch address on a word boundary
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
  ) else begin
    fail_count++;
    $error("pc is not word aligned");
  end

  // trace enables follow the decoder, never both kinds of write at once
  a_one_write_kind: assert property (
    @(posedge clk) !(rf_we && dm_we)
  ) else begin
    fail_count++;
    $error("register write and memory write in the same cycle");
  end

endmodule

// ==== testbench/mips_cpu_tb.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_cpu_tb;
  import mips_pkg::*;

  localparam int PROG_WORDS = 200;
  localparam int LOOP_START = 31;
  localparam int RUN_CYCLES = 1000;

  // one retired instruction as seen on the trace
  typedef struct packed {
    word_t     pc;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    logic      dm_we;
    word_t     dm_addr;
    word_t     dm_wdata;
  } trace_t;

  logic      clk;
  logic      reset;
  logic      load_we;
  word_t     load_addr;
  word_t     load_data;
  word_t     pc;
  word_t     rf_wdata;
  word_t     dm_addr;
  word_t     dm_wdata;
  reg_addr_t rf_waddr;
  logic      rf_we;
  logic      dm_we;

  // program image and model state
  word_t  prog [`MIPS_IMEM_WORDS];
  word_t  m_regs [32];
  word_t  m_dmem [`MIPS_DMEM_WORDS];
  word_t  m_pc;
  bit     compare_done;
  funct_t fn_list [5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};

  mips_cpu mips_cpu_i (
    .clk       (clk),
    .reset     (reset),
    .load_we   (load_we),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .rf_wdata  (rf_wdata),
    .dm_addr   (dm_addr),
    .dm_wdata  (dm_wdata),
    .rf_waddr  (rf_waddr),
    .rf_we     (rf_we),
    .dm_we     (dm_we)
  );

  bind mips_cpu mips_cpu_chk mips_cpu_chk_i (
    .clk   (clk),
    .reset (reset),
    .pc    (pc),
    .rf_we (rf_we),
    .dm_we (dm_we)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string field, input word_t got, input word_t want);
    if (got !== want) begin
      abort_run($sformatf("ERROR %0t: %s is %h, expected %h", $time, field, got, want));
    end
  endtask

  task automatic check_reg_addr(input string field, input reg_addr_t got,
                                input reg_addr_t want);
    if (got !== want) begin
      abort_run($sformatf("ERROR %0t: %s is %0d, expected %0d", $time, field, got, want));
    end
  endtask

  task automatic check_bit(input string field, input logic got, input logic want);
    if (got !== want) begin
      abort_run($sformatf("ERROR %0t: %s is %b, expected %b", $time, field, got, want));
    end
  endtask

  // address bits above bit 1, modulo the depth
  function automatic int word_index(input word_t addr, input int depth);
    return int'((addr >> 2) % depth);
  endfunction

  task automatic build_program();
    int        kind;
    int        off;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    for (int i = 0; i < `MIPS_IMEM_WORDS; i++) begin
      prog[i] = '0;
    end
    // r1..r31 from r0, small values so compares often tie
    for (int r = 1; r < 32; r++) begin
      prog[r - 1] = {OP_ADDI, 5'd0, 5'(r), 16'($urandom_range(0, 8)) - 16'd4};
    end
    for (int i = LOOP_START; i < PROG_WORDS - 1; i++) begin
      kind = $urandom_range(0, 9);
      rs   = 5'($urandom_range(0, 31));
      rt   = 5'($urandom_range(0, 31));
      rd   = 5'($urandom_range(0, 31));
      case (kind)
        0, 1, 2, 3: prog[i] = {OP_RTYPE, rs, rt, rd, 5'd0, fn_list[$urandom_range(0, 4)]};
        4: prog[i] = {OP_ADDI, rs, rt, 16'($urandom)};
        // base r0, word offsets in the low data words
        5: prog[i] = {OP_LW, 5'd0, rt, 16'(4 * $urandom_range(0, 15))};
        6: prog[i] = {OP_SW, 5'd0, rt, 16'(4 * $urandom_range(0, 15))};
        7, 8: begin
          if ($urandom_range(0, 1) == 1) begin
            rt = rs;
          end
          off = $urandom_range(0, 10) - 3;
          // target stays in the loop body
          if (i + 1 + off < LOOP_START) begin
            off = LOOP_START - i - 1;
          end
          if (i + 1 + off > PROG_WORDS - 1) begin
            off = PROG_WORDS - 2 - i;
          end
          // no branch onto itself
          if (off == -1) begin
            off = 0;
          end
          prog[i] = {(kind == 7) ? OP_BEQ : OP_BNE, rs, rt, 16'(off)};
        end
        default: begin
          prog[i] = {($urandom_range(0, 1) == 1) ? OP_JAL : OP_J,
                     26'($urandom_range(LOOP_START, PROG_WORDS - 1))};
        end
      endcase
    end
    // wrap back past the register setup
    prog[PROG_WORDS - 1] = {OP_J, 26'(LOOP_START)};
  endtask

  // executes one instruction on the model and commits it
  function automatic trace_t step_model();
    trace_t t;
    word_t  ins;
    word_t  a;
    word_t  b;
    word_t  imm_sx;
    word_t  pc4;
    word_t  next_pc;
    ins     = prog[word_index(m_pc, `MIPS_IMEM_WORDS)];
    a       = m_regs[ins[25:21]];
    b       = m_regs[ins[20:16]];
    imm_sx  = {{16{ins[15]}}, ins[15:0]};
    pc4     = m_pc + 32'd4;
    next_pc = pc4;
    t       = '0;
    t.pc    = m_pc;
    case (opcode_t'(ins[31:26]))
      OP_RTYPE: begin
        t.rf_we    = 1'b1;
        t.rf_waddr = ins[15:11];
        case (funct_t'(ins[5:0]))
          FN_ADD:  t.rf_wdata = a + b;
          FN_SUB:  t.rf_wdata = a - b;
          FN_AND:  t.rf_wdata = a & b;
          FN_OR:   t.rf_wdata = a | b;
          FN_SLT:  t.rf_wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: t.rf_we = 1'b0;
        endcase
      end
      OP_ADDI, OP_LW: begin
        t.rf_we    = 1'b1;
        t.rf_waddr = ins[20:16];
        t.rf_wdata = a + imm_sx;
        if (ins[31:26] == OP_LW) begin
          t.rf_wdata = m_dmem[word_index(a + imm_sx, `MIPS_DMEM_WORDS)];
        end
      end
      OP_SW: begin
        t.dm_we    = 1'b1;
        t.dm_addr  = a + imm_sx;
        t.dm_wdata = b;
      end
      OP_BEQ: if (a == b) next_pc = pc4 + (imm_sx << 2);
      OP_BNE: if (a != b) next_pc = pc4 + (imm_sx << 2);
      OP_J, OP_JAL: begin
        next_pc = {pc4[31:28], ins[25:0], 2'b00};
        if (ins[31:26] == OP_JAL) begin
          t.rf_we    = 1'b1;
          t.rf_waddr = REG_RA;
          t.rf_wdata = pc4;
        end
      end
      default: ;
    endcase
    // r0 never changes
    if (t.rf_we && t.rf_waddr != '0) begin
      m_regs[t.rf_waddr] = t.rf_wdata;
    end
    if (t.dm_we) begin
      m_dmem[word_index(t.dm_addr, `MIPS_DMEM_WORDS)] = t.dm_wdata;
    end
    m_pc = next_pc;
    return t;
  endfunction

  // stimulus: load during reset, then release
  initial begin
    int wait_cycles;
    void'($urandom(32'he84c));
    reset     = 1'b1;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    build_program();
    for (int i = 0; i < PROG_WORDS; i++) begin
      @(posedge clk);
      #1;
      load_we   = 1'b1;
      load_addr = word_t'(i * 4);
      load_data = prog[i];
    end
    @(posedge clk);
    #1;
    load_we = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles = 0;
    while (!compare_done && wait_cycles < RUN_CYCLES + 50) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (compare_done) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("timeout waiting for the trace comparison to finish");
    end
  end

  // watch the bound checker between edges
  always @(negedge clk) begin
    if (mips_cpu_i.mips_cpu_chk_i.fail_count != 0) begin
      abort_run("a bound assertion on the DUT failed");
    end
  end

  // compare the trace 1 ns before each rising edge
  initial begin
    int     waited;
    trace_t want;
    compare_done = 1'b0;
    m_pc = `MIPS_RESET_PC;
    for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
    end
    for (int w = 0; w < `MIPS_DMEM_WORDS; w++) begin
      m_dmem[w] = '0;
    end
    waited = 0;
    do begin
      @(posedge clk);
      #3;
      waited++;
      if (waited > PROG_WORDS + 50) begin
        abort_run("timeout waiting for reset to be released");
      end
      if (reset) begin
        check_word("pc", pc, `MIPS_RESET_PC);
        check_bit("rf_we", rf_we, 1'b0);
        check_bit("dm_we", dm_we, 1'b0);
      end
    end while (reset);
    for (int n = 0; n < RUN_CYCLES; n++) begin
      want = step_model();
      check_word("pc", pc, want.pc);
      check_bit("rf_we", rf_we, want.rf_we);
      check_bit("dm_we", dm_we, want.dm_we);
      // address and data only matter with the enable
      if (want.rf_we) begin
        check_reg_addr("rf_waddr", rf_waddr, want.rf_waddr);
        check_word("rf_wdata", rf_wdata, want.rf_wdata);
      end
      if (want.dm_we) begin
        check_word("dm_addr", dm_addr, want.dm_addr);
        check_word("dm_wdata", dm_wdata, want.dm_wdata);
      end
      @(posedge clk);
      #3;
    end
    compare_done = 1'b1;
  end

endmodule

// ==== filelist.f ====
+incdir+common
common/mips_pkg.sv
common/ctrl_if.sv
src/control_decoder.sv
src/pc_unit.sv
src/regfile.sv
src/execute_unit.sv
src/instr_mem.sv
src/data_ram.sv
src/mips_cpu.sv
testbench/mips_cpu_chk.sv
testbench/mips_cpu_tb.sv

// ==== Makefile ====
TOP = mips_cpu_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
